// ==== hdl/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define XLEN        32
`define NREGS       32
`define DMEM_WORDS  256
`define DMEM_AW     8
`define LINK_REG    5'd31

`define OP_RFORMAT  6'b000000
`define OP_LW       6'b100011
`define OP_SW       6'b101011
`define OP_BEQ      6'b000100
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_ANDI     6'b001100
`define OP_SPECIAL  6'b011100

`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_SLT      6'b101010
`define FN_MUL      6'b000010 // SPECIAL opcode only

`define ALUOP_ADD   2'b00
`define ALUOP_SUB   2'b01
`define ALUOP_FUNCT 2'b10
`define ALUOP_AND   2'b11

`endif

// ==== hdl/mips_pkg.sv ====
package mips_pkg;

    // One instruction word seen through the three MIPS encodings
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j;
    } mips_instr_u;

    typedef struct packed {
        logic       reg_dst;
        logic       jump;
        logic       branch;
        logic       mem_read;
        logic       mem_to_reg;
        logic       mem_write;
        logic       alu_src;
        logic       reg_write;
        logic       link;
        logic       mult;
        logic       is_rformat;
        logic [1:0] alu_op;
        logic       zero_ext; // Only ANDI treats its immediate as unsigned
    } ctrl_s;

    typedef enum logic [2:0] {
        FN_ADD_E = 3'd0,
        FN_SUB_E = 3'd1,
        FN_AND_E = 3'd2,
        FN_OR_E  = 3'd3,
        FN_SLT_E = 3'd4,
        FN_MUL_E = 3'd5
    } alu_fn_e;

endpackage

// ==== hdl/control_unit.sv ====
`timescale 1ns/100ps
`include "mips_consts.svh"

module control_unit (
    input  logic [5:0]     i_op_code,
    output mips_pkg::ctrl_s o_ctrl
);

    always_comb begin
        o_ctrl = '0; // Unknown opcodes leave every control inactive
        case (i_op_code)
            `OP_RFORMAT: begin
                o_ctrl.reg_dst    = 1'b1;
                o_ctrl.reg_write  = 1'b1;
                o_ctrl.is_rformat = 1'b1;
                o_ctrl.alu_op     = `ALUOP_FUNCT;
            end
            `OP_SPECIAL: begin
                o_ctrl.reg_dst   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.mult      = 1'b1;
                o_ctrl.alu_op    = `ALUOP_FUNCT;
            end
            `OP_LW: begin
                o_ctrl.mem_read   = 1'b1;
                o_ctrl.mem_to_reg = 1'b1;
                o_ctrl.alu_src    = 1'b1;
                o_ctrl.reg_write  = 1'b1;
            end
            `OP_SW: begin
                o_ctrl.mem_write = 1'b1;
                o_ctrl.alu_src   = 1'b1;
            end
            `OP_BEQ: begin
                o_ctrl.branch = 1'b1;
                o_ctrl.alu_op = `ALUOP_SUB; // Equality comes from the ALU zero flag
            end
            `OP_J: o_ctrl.jump = 1'b1;
            `OP_JAL: begin
                o_ctrl.jump      = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.link      = 1'b1;
            end
            `OP_ADDI, `OP_ADDIU: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            `OP_ANDI: begin
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.zero_ext  = 1'b1;
                o_ctrl.alu_op    = `ALUOP_AND;
            end
            default: ;
        endcase
    end

    // A load and a store never share one instruction
    a_no_rd_wr: assert property (@(i_op_code) !(o_ctrl.mem_read && o_ctrl.mem_write));

endmodule

// ==== hdl/alu_control.sv ====
`timescale 1ns/100ps
`include "mips_consts.svh"

module alu_control (
    input  logic [1:0]        i_alu_op,
    input  logic [5:0]        i_funct,
    input  logic              i_mult,
    output mips_pkg::alu_fn_e o_alu_fn
);
    import mips_pkg::*;

    always_comb begin
        case (i_alu_op)
            `ALUOP_ADD: o_alu_fn = FN_ADD_E; // Address and immediate arithmetic
            `ALUOP_SUB: o_alu_fn = FN_SUB_E;
            `ALUOP_AND: o_alu_fn = FN_AND_E;
            `ALUOP_FUNCT: begin
                if (i_mult) begin
                    o_alu_fn = FN_MUL_E; // SPECIAL opcode carries only the multiply
                end else begin
                    case (i_funct)
                        `FN_ADD,
                        `FN_ADDU: o_alu_fn = FN_ADD_E; // Both add alike as there is no overflow trap
                        `FN_SUB:  o_alu_fn = FN_SUB_E;
                        `FN_AND:  o_alu_fn = FN_AND_E;
                        `FN_OR:   o_alu_fn = FN_OR_E;
                        `FN_SLT:  o_alu_fn = FN_SLT_E;
                        default:  o_alu_fn = FN_ADD_E;
                    endcase
                end
            end
            default: o_alu_fn = FN_ADD_E;
        endcase
    end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/100ps
`include "mips_consts.svh"

module alu (
    input  logic [`XLEN-1:0]  i_a,
    input  logic [`XLEN-1:0]  i_b,
    input  mips_pkg::alu_fn_e i_fn,
    output logic [`XLEN-1:0]  o_result,
    output logic              o_zero
);
    import mips_pkg::*;

    logic [`XLEN-1:0] diff;
    logic             less;

    assign diff = i_a - i_b;
    assign less = $signed(i_a) < $signed(i_b);

    always_comb begin
        case (i_fn)
            FN_ADD_E: o_result = i_a + i_b;
            FN_SUB_E: o_result = diff;
            FN_AND_E: o_result = i_a & i_b;
            FN_OR_E:  o_result = i_a | i_b;
            FN_SLT_E: o_result = {{(`XLEN-1){1'b0}}, less};
            FN_MUL_E: o_result = i_a * i_b; // Low word of the product
            default:  o_result = i_a + i_b;
        endcase
    end

    // BEQ reads equality from the difference whatever the function
    assign o_zero = (diff == '0);

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/100ps
`include "mips_consts.svh"

module register_file (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic [4:0]       i_ra1,
    input  logic [4:0]       i_ra2,
    input  logic [4:0]       i_wa,
    input  logic             i_we,
    input  logic [`XLEN-1:0] i_wd,
    output logic [`XLEN-1:0] o_rd1,
    output logic [`XLEN-1:0] o_rd2
);

    logic [`XLEN-1:0] regs [`NREGS];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int k = 0; k < `NREGS; k++) begin
                regs[k] <= '0;
            end
        end else if (i_we && (i_wa != 5'd0)) begin
            regs[i_wa] <= i_wd; // Writes to $zero are dropped
        end
    end

    assign o_rd1 = (i_ra1 == 5'd0) ? '0 : regs[i_ra1];
    assign o_rd2 = (i_ra2 == 5'd0) ? '0 : regs[i_ra2];

    // Storage behind $zero keeps its reset value for the whole run
    a_zero_reg: assert property (@(posedge i_clk) disable iff (!i_rst_n) regs[0] == '0);

endmodule

// ==== hdl/data_memory.sv ====
`timescale 1ns/100ps
`include "mips_consts.svh"

module data_memory (
    input  logic               i_clk,
    input  logic               i_we,
    input  logic [`DMEM_AW-1:0] i_addr,
    input  logic [`XLEN-1:0]   i_wd,
    output logic [`XLEN-1:0]   o_rd
);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wd;
        end
    end

    assign o_rd = mem[i_addr]; // Load data is ready in the same cycle

endmodule

// ==== hdl/mips_core.sv ====
`timescale 1ns/100ps
`include "mips_consts.svh"

module mips_core (
    input  logic             i_clk,
    input  logic             i_rst_n,
    output logic [`XLEN-1:0] o_imem_addr,
    input  logic [`XLEN-1:0] i_imem_instr,
    output logic [`XLEN-1:0] o_pc,
    output logic             o_wb_en,
    output logic [4:0]       o_wb_reg,
    output logic [`XLEN-1:0] o_wb_data
);
    import mips_pkg::*;

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] branch_target;
    logic [`XLEN-1:0] jump_target;
    mips_instr_u      instr;
    ctrl_s            ctrl;
    alu_fn_e          alu_fn;
    logic [`XLEN-1:0] rd1;
    logic [`XLEN-1:0] rd2;
    logic [`XLEN-1:0] imm_sext;
    logic [`XLEN-1:0] imm_ext;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_result;
    logic             alu_zero;
    logic [`XLEN-1:0] mem_rd;
    logic             mem_we;
    logic [4:0]       wb_reg;
    logic [`XLEN-1:0] wb_data;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    assign o_imem_addr = pc;
    assign instr       = mips_instr_u'(i_imem_instr);

    control_unit u_control (
        .i_op_code (instr.r.opcode),
        .o_ctrl    (ctrl)
    );

    alu_control u_alu_control (
        .i_alu_op (ctrl.alu_op),
        .i_funct  (instr.r.funct),
        .i_mult   (ctrl.mult),
        .o_alu_fn (alu_fn)
    );

    register_file u_regs (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ra1   (instr.r.rs),
        .i_ra2   (instr.r.rt),
        .i_wa    (wb_reg),
        .i_we    (ctrl.reg_write),
        .i_wd    (wb_data),
        .o_rd1   (rd1),
        .o_rd2   (rd2)
    );

    assign imm_sext = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign imm_ext  = ctrl.zero_ext ? {16'b0, instr.i.imm} : imm_sext;
    assign alu_b    = ctrl.alu_src ? imm_ext : rd2;

    alu u_alu (
        .i_a      (rd1),
        .i_b      (alu_b),
        .i_fn     (alu_fn),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

    assign mem_we = ctrl.mem_write & i_rst_n; // No stray stores while reset is held

    data_memory u_dmem (
        .i_clk  (i_clk),
        .i_we   (mem_we),
        .i_addr (alu_result[`DMEM_AW+1:2]), // Word index with the byte offset dropped
        .i_wd   (rd2),
        .o_rd   (mem_rd)
    );

    assign wb_reg  = ctrl.link    ? `LINK_REG :
                     ctrl.reg_dst ? instr.r.rd : instr.r.rt;
    assign wb_data = ctrl.link       ? pc_plus4 :
                     ctrl.mem_to_reg ? mem_rd : alu_result;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {imm_sext[`XLEN-3:0], 2'b00};
    assign jump_target   = {pc_plus4[`XLEN-1 -: 4], instr.j.target, 2'b00};

    always_comb begin
        if (ctrl.jump) begin
            next_pc = jump_target;
        end else if (ctrl.branch && alu_zero) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    assign o_pc      = pc;
    assign o_wb_en   = ctrl.reg_write & i_rst_n;
    assign o_wb_reg  = wb_reg;
    assign o_wb_data = wb_data;

    // Every path into the PC keeps the two low bits clear
    a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n) pc[1:0] == 2'b00);

endmodule

// ==== test/tb_mips_core.sv ====
`timescale 1ns/100ps
`include "mips_consts.svh"

module tb_mips_core;
    import mips_pkg::*;

    typedef struct packed {
        logic        wb_en;
        logic [4:0]  wb_reg;
        logic [31:0] wb_data;
        logic        data_known; // Cleared for a load from a word never stored
        logic [31:0] next_pc;
    } step_s;

    localparam int n_sec = 6;
    localparam int sec_timeout = 200;

    logic        i_clk;
    logic        i_rst_n;
    logic [31:0] o_imem_addr;
    logic [31:0] i_imem_instr;
    logic [31:0] o_pc;
    logic        o_wb_en;
    logic [4:0]  o_wb_reg;
    logic [31:0] o_wb_data;

    logic [31:0] prog [256];
    logic [31:0] m_regs [32];
    logic [31:0] m_mem [256];
    logic        m_mem_valid [256];
    logic [31:0] m_pc;
    mips_instr_u cur;
    logic [31:0] op_a, op_b, imm_s, pc4, ea;
    step_s       want;
    logic [31:0] sec_start [n_sec + 1];
    string       sec_name [n_sec];
    int          wp, errors, checked, wait_cycles, err_before, done_secs;
    bit          timed_out;

    mips_core dut (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .o_imem_addr  (o_imem_addr),
        .i_imem_instr (i_imem_instr),
        .o_pc         (o_pc),
        .o_wb_en      (o_wb_en),
        .o_wb_reg     (o_wb_reg),
        .o_wb_data    (o_wb_data)
    );

    always #4 i_clk = ~i_clk;

    assign i_imem_instr = prog[o_imem_addr[9:2]]; // Fetch answers in the same cycle

    function automatic logic [31:0] enc_r(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [5:0] fn);
        return {op, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [31:0] byte_addr);
        return {op, byte_addr[27:2]};
    endfunction

    function automatic logic [4:0] rand_reg(input int hi);
        return 5'(1 + $urandom % hi);
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[wp] = word;
        wp++;
    endtask

    task automatic start_section(input int n, input string name);
        sec_start[n] = 32'(wp * 4);
        sec_name[n]  = name;
    endtask

    task automatic report_value(input string name, input logic [31:0] exp_v,
                                input logic [31:0] got_v);
        errors++;
        $display("error %0t %s expected %h actual %h", $time, name, exp_v, got_v);
    endtask

    task automatic build_program();
        logic [5:0]  fns [6];
        logic [15:0] imm;
        int          idx [4];
        int          off;
        fns = '{`FN_ADD, `FN_ADDU, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT};
        for (int k = 0; k < 256; k++) begin
            prog[k] = enc_j(`OP_J, 32'(k * 4)); // Each unused word spins on its own address
        end
        wp = 0;
        start_section(0, "immediates");
        for (int r = 1; r <= 10; r++) begin
            imm = 16'($urandom);
            if (r <= 3) imm[15] = 1'b1;
            if (r >= 8) imm[15] = 1'b0;
            emit(enc_i((r % 2) ? `OP_ADDI : `OP_ADDIU, 5'd0, 5'(r), imm));
        end
        for (int r = 11; r <= 13; r++) begin
            emit(enc_i(`OP_ANDI, 5'(r - 10), 5'(r), 16'($urandom) | 16'h8000));
        end
        emit(enc_i(`OP_ADDI, 5'd1, 5'd0, 16'($urandom)));
        emit(enc_r(`OP_RFORMAT, 5'd0, 5'd0, 5'd14, `FN_ADD)); // $zero must still read 0
        emit(enc_j(`OP_J, 32'((wp + 1) * 4)));
        start_section(1, "r-format");
        emit(enc_r(`OP_RFORMAT, 5'd1, 5'd8, 5'd16, `FN_SLT)); // Negative against positive
        emit(enc_r(`OP_RFORMAT, 5'd8, 5'd1, 5'd17, `FN_SLT));
        for (int k = 0; k < 12; k++) begin
            emit(enc_r(`OP_RFORMAT, rand_reg(13), rand_reg(13), rand_reg(20), fns[$urandom % 6]));
        end
        emit(enc_j(`OP_J, 32'((wp + 1) * 4)));
        start_section(2, "multiply");
        for (int k = 0; k < 6; k++) begin
            emit(enc_r(`OP_SPECIAL, rand_reg(20), rand_reg(20), rand_reg(20), `FN_MUL));
        end
        emit(enc_j(`OP_J, 32'((wp + 1) * 4)));
        start_section(3, "load/store");
        for (int k = 0; k < 4; k++) begin
            idx[k] = int'($urandom % 256);
            emit(enc_i(`OP_SW, 5'd0, rand_reg(20), 16'(idx[k] * 4)));
        end
        for (int k = 3; k >= 0; k--) begin
            emit(enc_i(`OP_LW, 5'd0, 5'(21 + k), 16'(idx[k] * 4)));
        end
        emit(enc_j(`OP_J, 32'((wp + 1) * 4)));
        start_section(4, "branch");
        emit(enc_i(`OP_ADDI, 5'd0, 5'd24, 16'd5));
        emit(enc_i(`OP_ADDI, 5'd0, 5'd25, 16'd6));
        for (int k = 0; k < 4; k++) begin
            off = 1 + int'($urandom % 3);
            emit(enc_i(`OP_BEQ, 5'd24, (k % 2) ? 5'd24 : 5'd25, 16'(off)));
            for (int p = 0; p < off; p++) begin
                emit(enc_i(`OP_ADDI, 5'd26, 5'd26, 16'd1)); // Runs only on a branch not taken
            end
        end
        emit(enc_j(`OP_J, 32'((wp + 1) * 4)));
        start_section(5, "jumps");
        emit(enc_j(`OP_J, 32'((wp + 3) * 4)));
        emit(enc_i(`OP_ADDI, 5'd26, 5'd26, 16'd1));
        emit(enc_i(`OP_ADDI, 5'd26, 5'd26, 16'd1));
        emit(enc_j(`OP_JAL, 32'((wp + 2) * 4)));
        emit(enc_i(`OP_ADDI, 5'd26, 5'd26, 16'd1));
        emit(enc_r(`OP_RFORMAT, 5'd31, 5'd0, 5'd27, `FN_ADD));
        emit(enc_j(`OP_J, 32'((wp + 1) * 4)));
        sec_start[n_sec] = 32'(wp * 4);
        emit(enc_j(`OP_J, 32'(wp * 4))); // Parks the core once the program is done
    endtask

    // ISA view of the instruction at the model's PC
    always_comb begin
        cur   = mips_instr_u'(prog[m_pc[9:2]]);
        op_a  = m_regs[cur.r.rs];
        op_b  = m_regs[cur.r.rt];
        imm_s = {{16{cur.i.imm[15]}}, cur.i.imm};
        pc4   = m_pc + 32'd4;
        ea    = op_a + imm_s;
        want  = '0;
        want.data_known = 1'b1;
        want.next_pc    = pc4;
        case (cur.r.opcode)
            `OP_RFORMAT: begin
                want.wb_en  = 1'b1;
                want.wb_reg = cur.r.rd;
                case (cur.r.funct)
                    `FN_SUB: want.wb_data = op_a - op_b;
                    `FN_AND: want.wb_data = op_a & op_b;
                    `FN_OR:  want.wb_data = op_a | op_b;
                    `FN_SLT: want.wb_data = {31'd0, ($signed(op_a) < $signed(op_b))};
                    default: want.wb_data = op_a + op_b; // ADD, ADDU and any other funct
                endcase
            end
            `OP_SPECIAL: begin
                want.wb_en   = 1'b1;
                want.wb_reg  = cur.r.rd;
                want.wb_data = op_a * op_b;
            end
            `OP_ADDI, `OP_ADDIU: begin
                want.wb_en   = 1'b1;
                want.wb_reg  = cur.i.rt;
                want.wb_data = ea;
            end
            `OP_ANDI: begin
                want.wb_en   = 1'b1;
                want.wb_reg  = cur.i.rt;
                want.wb_data = op_a & {16'd0, cur.i.imm};
            end
            `OP_LW: begin
                want.wb_en      = 1'b1;
                want.wb_reg     = cur.i.rt;
                want.wb_data    = m_mem[ea[9:2]];
                want.data_known = m_mem_valid[ea[9:2]];
            end
            `OP_BEQ: if (op_a == op_b) want.next_pc = pc4 + {imm_s[29:0], 2'b00};
            `OP_J:   want.next_pc = {pc4[31:28], cur.j.target, 2'b00};
            `OP_JAL: begin
                want.next_pc = {pc4[31:28], cur.j.target, 2'b00};
                want.wb_en   = 1'b1;
                want.wb_reg  = `LINK_REG;
                want.wb_data = pc4;
            end
            default: ;
        endcase
        want.wb_en = want.wb_en & i_rst_n;
    end

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            m_pc <= '0;
            for (int k = 0; k < 32; k++) m_regs[k] <= '0;
            for (int k = 0; k < 256; k++) m_mem_valid[k] <= 1'b0;
        end else begin
            checked++;
            m_pc <= want.next_pc;
            if (want.wb_en && want.wb_reg != 5'd0) m_regs[want.wb_reg] <= want.wb_data;
            if (cur.r.opcode == `OP_SW) begin
                m_mem[ea[9:2]]       <= op_b;
                m_mem_valid[ea[9:2]] <= 1'b1;
            end
        end
    end

    a_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_pc == m_pc)
        else report_value("o_pc", $sampled(m_pc), $sampled(o_pc));
    a_imem_addr: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_imem_addr == m_pc)
        else report_value("o_imem_addr", $sampled(m_pc), $sampled(o_imem_addr));
    // Also holds while reset is asserted, when no write-back may be shown
    a_wb_en: assert property (@(posedge i_clk) o_wb_en == want.wb_en)
        else report_value("o_wb_en", 32'($sampled(want.wb_en)), 32'($sampled(o_wb_en)));
    a_wb_reg: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !want.wb_en || o_wb_reg == want.wb_reg)
        else report_value("o_wb_reg", 32'($sampled(want.wb_reg)), 32'($sampled(o_wb_reg)));
    a_wb_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(want.wb_en && want.data_known) || o_wb_data == want.wb_data)
        else report_value("o_wb_data", $sampled(want.wb_data), $sampled(o_wb_data));

    initial begin
        i_clk     = 1'b0;
        i_rst_n   = 1'b0;
        errors    = 0;
        checked   = 0;
        done_secs = 0;
        timed_out = 1'b0;
        void'($urandom(32'ha024));
        build_program();
        repeat (8) @(posedge i_clk);
        i_rst_n <= 1'b1;
        for (int s = 0; s < n_sec && !timed_out; s++) begin
            err_before  = errors;
            wait_cycles = 0;
            while (m_pc != sec_start[s + 1] && wait_cycles < sec_timeout) begin
                @(posedge i_clk);
                wait_cycles++;
            end
            if (m_pc != sec_start[s + 1]) begin
                $display("timeout: section %s never reached its closing jump within %0d cycles",
                         sec_name[s], sec_timeout);
                timed_out = 1'b1;
            end else begin
                done_secs++;
                $display("section %s: %0d errors", sec_name[s], errors - err_before);
            end
        end
        @(posedge i_clk);
        $display("sections finished %0d of %0d, cycles checked %0d, errors %0d",
                 done_secs, n_sec, checked, errors);
        if (errors == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/mips_pkg.sv
hdl/control_unit.sv
hdl/alu_control.sv
hdl/alu.sv
hdl/register_file.sv
hdl/data_memory.sv
hdl/mips_core.sv
test/tb_mips_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Done: errors found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
